/* idq_cfg_pkg.sv */
`default_nettype none

package idq_cfg_pkg;

    // Width of the ID that every stored element carries
    localparam int ID_WIDTH = 3;

    // Maximum number of stored elements over all IDs together
    localparam int CAPACITY = 8;

    // Width of an element's payload, also used for the search word and mask
    localparam int DATA_WIDTH = 16;

    // Number of distinct IDs that the ID field can express
    localparam int NUM_IDS = 2 ** ID_WIDTH;

    // The head-tail table never needs more entries than there are IDs or elements
    localparam int HT_CAPACITY = (NUM_IDS <= CAPACITY) ? NUM_IDS : CAPACITY;

    // Index widths into the two tables
    localparam int LD_IDX_WIDTH = $clog2(CAPACITY);
    localparam int HT_IDX_WIDTH = $clog2(HT_CAPACITY);

    // Element ID
    typedef logic [ID_WIDTH-1:0] id_t;

    // Element payload, search word and search mask
    typedef logic [DATA_WIDTH-1:0] data_t;

    // Slot number in the linked data table
    typedef logic [LD_IDX_WIDTH-1:0] ld_idx_t;

    // Entry number in the head-tail table
    typedef logic [HT_IDX_WIDTH-1:0] ht_idx_t;

endpackage

`default_nettype wire

/* idq_op_pkg.sv */
`default_nettype none

package idq_op_pkg;

    // Access that the arbiter grants in the current cycle
    // Only one of push, read and pop can happen per cycle (half bandwidth)
    typedef enum logic [1:0] {
        // No access, the tables hold their contents
        OP_IDLE = 2'd0,
        // Append an element to the subqueue of its ID
        OP_PUSH = 2'd1,
        // Return the head of an ID and leave it in place
        OP_READ = 2'd2,
        // Return the head of an ID and remove it
        OP_POP  = 2'd3
    } op_e;

endpackage

`default_nettype wire

/* idq_port_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module idq_port_arbiter (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                inp_req_i,
    input  logic                oup_req_i,
    input  logic                oup_pop_i,
    input  logic                full_i,
    input  idq_cfg_pkg::id_t    inp_id_i,
    input  idq_cfg_pkg::id_t    oup_id_i,
    output logic                inp_gnt_o,
    output logic                oup_gnt_o,
    output logic                alloc_o,
    output idq_op_pkg::op_e     op_o,
    output idq_cfg_pkg::id_t    match_id_o
);

    logic push_win;

    // The input side accepts whenever a slot is free
    assign inp_gnt_o = !full_i;

    // A push handshake takes the single access slot of this cycle
    assign push_win = inp_req_i && !full_i;

    // Output requests are always served unless a push owns the slot
    assign oup_gnt_o = oup_req_i && !push_win;

    always_comb begin
        op_o = idq_op_pkg::OP_IDLE;
        if (push_win) begin
            op_o = idq_op_pkg::OP_PUSH;
        end else if (oup_req_i) begin
            // Without pop the head is only looked at
            op_o = oup_pop_i ? idq_op_pkg::OP_POP : idq_op_pkg::OP_READ;
        end
    end

    // The head-tail table searches for the ID of whichever side won
    assign match_id_o = push_win ? inp_id_i : oup_id_i;

    // A push always needs a fresh slot in the data table
    assign alloc_o = (op_o == idq_op_pkg::OP_PUSH);

    // A push refused for lack of space has no buffer, so it stays requested
    a_push_held: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (inp_req_i && !inp_gnt_o) |=> inp_req_i
    ) else $error("Refused push request was dropped before its grant");

endmodule

`default_nettype wire

/* idq_head_tail_table.sv */
`timescale 1ns/1ps
`default_nettype none

module idq_head_tail_table (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  idq_op_pkg::op_e         op_i,
    input  idq_cfg_pkg::id_t        match_id_i,
    input  idq_cfg_pkg::ld_idx_t    free_idx_i,
    input  idq_cfg_pkg::ld_idx_t    rd_next_i,
    output logic                    hit_o,
    output logic                    link_o,
    output logic                    release_o,
    output idq_cfg_pkg::ld_idx_t    rd_idx_o,
    output idq_cfg_pkg::ld_idx_t    link_idx_o,
    output idq_cfg_pkg::ld_idx_t    release_idx_o
);

    // One entry per active ID, holding the ends of its linked subqueue
    idq_cfg_pkg::id_t       ht_id_q   [idq_cfg_pkg::HT_CAPACITY];
    idq_cfg_pkg::ld_idx_t   ht_head_q [idq_cfg_pkg::HT_CAPACITY];
    idq_cfg_pkg::ld_idx_t   ht_tail_q [idq_cfg_pkg::HT_CAPACITY];
    logic [idq_cfg_pkg::HT_CAPACITY-1:0] ht_free_q;

    logic [idq_cfg_pkg::HT_CAPACITY-1:0] match_vec;
    idq_cfg_pkg::ht_idx_t   match_idx;
    idq_cfg_pkg::ht_idx_t   free_ht_idx;
    logic                   id_present;
    logic                   is_output;
    logic                   head_is_tail;

    // Scan from the top so that the lowest matching and lowest free entries win
    always_comb begin
        match_vec   = '0;
        match_idx   = '0;
        free_ht_idx = '0;
        for (int i = idq_cfg_pkg::HT_CAPACITY - 1; i >= 0; i--) begin
            // Free entries hold stale IDs and must not match
            match_vec[i] = !ht_free_q[i] && (ht_id_q[i] == match_id_i);
            if (match_vec[i]) begin
                match_idx = idq_cfg_pkg::ht_idx_t'(i);
            end
            if (ht_free_q[i]) begin
                free_ht_idx = idq_cfg_pkg::ht_idx_t'(i);
            end
        end
    end

    assign id_present = |match_vec;
    assign is_output  = (op_i == idq_op_pkg::OP_READ) || (op_i == idq_op_pkg::OP_POP);

    // Valid output data only for a granted read or pop of a present ID
    assign hit_o    = id_present && is_output;
    assign rd_idx_o = ht_head_q[match_idx];

    // Appending to an existing subqueue chains the old tail to the new slot
    assign link_o     = id_present && (op_i == idq_op_pkg::OP_PUSH);
    assign link_idx_o = ht_tail_q[match_idx];

    // A pop hands the old head back to the free pool
    assign release_o     = id_present && (op_i == idq_op_pkg::OP_POP);
    assign release_idx_o = ht_head_q[match_idx];

    // The last element of an ID sits in both head and tail
    assign head_is_tail = (ht_head_q[match_idx] == ht_tail_q[match_idx]);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ht_free_q <= '1;
            for (int i = 0; i < idq_cfg_pkg::HT_CAPACITY; i++) begin
                ht_id_q[i]   <= '0;
                ht_head_q[i] <= '0;
                ht_tail_q[i] <= '0;
            end
        end else begin
            case (op_i)
                idq_op_pkg::OP_PUSH: begin
                    if (id_present) begin
                        // Existing ID, the new slot becomes its tail
                        ht_tail_q[match_idx] <= free_idx_i;
                    end else begin
                        // New ID, open an entry with a one-element subqueue
                        ht_id_q[free_ht_idx]   <= match_id_i;
                        ht_head_q[free_ht_idx] <= free_idx_i;
                        ht_tail_q[free_ht_idx] <= free_idx_i;
                        ht_free_q[free_ht_idx] <= 1'b0;
                    end
                end
                idq_op_pkg::OP_POP: begin
                    if (id_present) begin
                        if (head_is_tail) begin
                            // Subqueue is now empty, so the ID leaves the table
                            ht_free_q[match_idx] <= 1'b1;
                        end else begin
                            ht_head_q[match_idx] <= rd_next_i;
                        end
                    end
                end
                default: begin
                    // Reads and idle cycles leave the table untouched
                end
            endcase
        end
    end

    // Each ID owns at most one entry, which the push path must keep true
    a_unique_match: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        $onehot0(match_vec)
    ) else $error("Several head-tail entries match the same ID");

endmodule

`default_nettype wire

/* idq_linked_data_table.sv */
`timescale 1ns/1ps
`default_nettype none

module idq_linked_data_table (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    alloc_i,
    input  logic                    link_i,
    input  logic                    release_i,
    input  idq_cfg_pkg::data_t      inp_data_i,
    input  idq_cfg_pkg::ld_idx_t    link_idx_i,
    input  idq_cfg_pkg::ld_idx_t    release_idx_i,
    input  idq_cfg_pkg::ld_idx_t    rd_idx_i,
    output idq_cfg_pkg::ld_idx_t    free_idx_o,
    output idq_cfg_pkg::ld_idx_t    rd_next_o,
    output idq_cfg_pkg::data_t      rd_data_o,
    output logic                    full_o,
    output idq_cfg_pkg::data_t [idq_cfg_pkg::CAPACITY-1:0] occ_data_o,
    output logic [idq_cfg_pkg::CAPACITY-1:0]               occ_valid_o
);

    // Element storage, each slot also points at the next element of its ID
    idq_cfg_pkg::data_t   data_q [idq_cfg_pkg::CAPACITY];
    idq_cfg_pkg::ld_idx_t next_q [idq_cfg_pkg::CAPACITY];
    logic [idq_cfg_pkg::CAPACITY-1:0] free_q;

    // Lowest free slot, found by scanning downwards
    always_comb begin
        free_idx_o = '0;
        for (int i = idq_cfg_pkg::CAPACITY - 1; i >= 0; i--) begin
            if (free_q[i]) begin
                free_idx_o = idq_cfg_pkg::ld_idx_t'(i);
            end
        end
    end

    // No free slot left means the queue is full
    assign full_o = ~|free_q;

    // Head lookup for the output port and for advancing the head on a pop
    assign rd_data_o = data_q[rd_idx_i];
    assign rd_next_o = next_q[rd_idx_i];

    // All slots go to the search, qualified by occupancy
    always_comb begin
        for (int i = 0; i < idq_cfg_pkg::CAPACITY; i++) begin
            occ_data_o[i] = data_q[i];
        end
    end
    assign occ_valid_o = ~free_q;

    // A push stores its payload in the lowest free slot
    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            data_q[free_idx_o] <= inp_data_i;
        end
        if (link_i) begin
            // The old tail of the pushed ID now points at the new slot
            next_q[link_idx_i] <= free_idx_o;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            free_q <= '1;
        end else begin
            if (alloc_i) begin
                free_q[free_idx_o] <= 1'b0;
            end
            if (release_i) begin
                free_q[release_idx_i] <= 1'b1;
            end
        end
    end

    // The arbiter must hold back pushes while every slot is taken
    a_no_alloc_full: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        alloc_i |-> !full_o
    ) else $error("Allocation requested while the data table is full");

endmodule

`default_nettype wire

/* idq_exists_search.sv */
`timescale 1ns/1ps
`default_nettype none

module idq_exists_search (
    input  logic                exists_req_i,
    input  idq_cfg_pkg::data_t  exists_data_i,
    input  idq_cfg_pkg::data_t  exists_mask_i,
    input  idq_cfg_pkg::data_t [idq_cfg_pkg::CAPACITY-1:0] occ_data_i,
    input  logic [idq_cfg_pkg::CAPACITY-1:0]               occ_valid_i,
    output logic                exists_o,
    output logic                exists_gnt_o
);

    logic [idq_cfg_pkg::CAPACITY-1:0] slot_match;

    // A slot matches when it is occupied and no masked bit differs
    always_comb begin
        for (int i = 0; i < idq_cfg_pkg::CAPACITY; i++) begin
            // Bits outside the mask are ignored, so an empty mask matches any stored word
            slot_match[i] = occ_valid_i[i] &&
                            (((occ_data_i[i] ^ exists_data_i) & exists_mask_i) == '0);
        end
    end

    // The search never conflicts with push or pop, so it is granted at once
    assign exists_gnt_o = exists_req_i;

    // One hit anywhere in the queue is enough
    assign exists_o = exists_req_i && (|slot_match);

endmodule

`default_nettype wire

/* id_queue_top.sv */
`timescale 1ns/1ps
`default_nettype none

module id_queue_top (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                inp_req_i,
    input  idq_cfg_pkg::id_t    inp_id_i,
    input  idq_cfg_pkg::data_t  inp_data_i,
    output logic                inp_gnt_o,
    input  logic                oup_req_i,
    input  idq_cfg_pkg::id_t    oup_id_i,
    input  logic                oup_pop_i,
    output logic                oup_gnt_o,
    output idq_cfg_pkg::data_t  oup_data_o,
    output logic                oup_data_valid_o,
    input  logic                exists_req_i,
    input  idq_cfg_pkg::data_t  exists_data_i,
    input  idq_cfg_pkg::data_t  exists_mask_i,
    output logic                exists_o,
    output logic                exists_gnt_o
);

    idq_op_pkg::op_e        op;
    idq_cfg_pkg::id_t       match_id;
    logic                   alloc;
    logic                   full;
    logic                   link;
    logic                   ld_release;
    idq_cfg_pkg::ld_idx_t   free_idx;
    idq_cfg_pkg::ld_idx_t   rd_idx;
    idq_cfg_pkg::ld_idx_t   rd_next;
    idq_cfg_pkg::ld_idx_t   link_idx;
    idq_cfg_pkg::ld_idx_t   release_idx;
    idq_cfg_pkg::data_t [idq_cfg_pkg::CAPACITY-1:0] occ_data;
    logic [idq_cfg_pkg::CAPACITY-1:0]               occ_valid;

    // Picks the single access of this cycle, push first
    idq_port_arbiter u_arbiter (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .inp_req_i  (inp_req_i),
        .oup_req_i  (oup_req_i),
        .oup_pop_i  (oup_pop_i),
        .full_i     (full),
        .inp_id_i   (inp_id_i),
        .oup_id_i   (oup_id_i),
        .inp_gnt_o  (inp_gnt_o),
        .oup_gnt_o  (oup_gnt_o),
        .alloc_o    (alloc),
        .op_o       (op),
        .match_id_o (match_id)
    );

    // Decides presence of an ID and drives the data table's commands
    idq_head_tail_table u_head_tail (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .op_i          (op),
        .match_id_i    (match_id),
        .free_idx_i    (free_idx),
        .rd_next_i     (rd_next),
        .hit_o         (oup_data_valid_o),
        .link_o        (link),
        .release_o     (ld_release),
        .rd_idx_o      (rd_idx),
        .link_idx_o    (link_idx),
        .release_idx_o (release_idx)
    );

    idq_linked_data_table u_linked_data (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .alloc_i       (alloc),
        .link_i        (link),
        .release_i     (ld_release),
        .inp_data_i    (inp_data_i),
        .link_idx_i    (link_idx),
        .release_idx_i (release_idx),
        .rd_idx_i      (rd_idx),
        .free_idx_o    (free_idx),
        .rd_next_o     (rd_next),
        .rd_data_o     (oup_data_o),
        .full_o        (full),
        .occ_data_o    (occ_data),
        .occ_valid_o   (occ_valid)
    );

    // Runs on the stored words alone, independent of push and pop
    idq_exists_search u_exists (
        .exists_req_i  (exists_req_i),
        .exists_data_i (exists_data_i),
        .exists_mask_i (exists_mask_i),
        .occ_data_i    (occ_data),
        .occ_valid_i   (occ_valid),
        .exists_o      (exists_o),
        .exists_gnt_o  (exists_gnt_o)
    );

endmodule

`default_nettype wire

/* tb_id_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_id_queue;

    // Each data line is 20 hex digits, see the column notes in the data file
    localparam int VEC_WIDTH = 80;
    localparam int MAX_LINES = 64;

    logic clk_i = 1'b0;
    logic rst_ni;

    logic               inp_req_i;
    idq_cfg_pkg::id_t   inp_id_i;
    idq_cfg_pkg::data_t inp_data_i;
    logic               inp_gnt_o;
    logic               oup_req_i;
    idq_cfg_pkg::id_t   oup_id_i;
    logic               oup_pop_i;
    logic               oup_gnt_o;
    idq_cfg_pkg::data_t oup_data_o;
    logic               oup_data_valid_o;
    logic               exists_req_i;
    idq_cfg_pkg::data_t exists_data_i;
    idq_cfg_pkg::data_t exists_mask_i;
    logic               exists_o;
    logic               exists_gnt_o;

    logic [VEC_WIDTH-1:0] vectors [MAX_LINES];
    int line_no = 0;
    int cycle_count = 0;
    int timeout_limit = 0;

    id_queue_top DUT (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .inp_req_i        (inp_req_i),
        .inp_id_i         (inp_id_i),
        .inp_data_i       (inp_data_i),
        .inp_gnt_o        (inp_gnt_o),
        .oup_req_i        (oup_req_i),
        .oup_id_i         (oup_id_i),
        .oup_pop_i        (oup_pop_i),
        .oup_gnt_o        (oup_gnt_o),
        .oup_data_o       (oup_data_o),
        .oup_data_valid_o (oup_data_valid_o),
        .exists_req_i     (exists_req_i),
        .exists_data_i    (exists_data_i),
        .exists_mask_i    (exists_mask_i),
        .exists_o         (exists_o),
        .exists_gnt_o     (exists_gnt_o)
    );

    // 8 ns clock period
    always #4 clk_i = ~clk_i;

    // The limit stays zero until the number of data lines is known
    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("TESTBENCH FAILED");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("CHECK FAILED line %0d: %s expected 0x%h actual 0x%h",
                     line_no, name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_data(input string name, input idq_cfg_pkg::data_t expected,
                              input idq_cfg_pkg::data_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED line %0d: %s expected 0x%h actual 0x%h",
                     line_no, name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // The op digit carries the request strobes: push, output, pop, search
    task automatic apply_vector(input logic [VEC_WIDTH-1:0] vec);
        inp_req_i     = vec[79];
        oup_req_i     = vec[78];
        oup_pop_i     = vec[77];
        exists_req_i  = vec[76];
        inp_id_i      = vec[74:72];
        inp_data_i    = vec[71:56];
        oup_id_i      = vec[54:52];
        exists_data_i = vec[51:36];
        exists_mask_i = vec[35:20];
    endtask

    task automatic check_outputs(input logic [VEC_WIDTH-1:0] vec);
        logic [3:0] flags;
        flags = vec[19:16];
        check_bit("inp_gnt_o", flags[3], inp_gnt_o);
        check_bit("oup_gnt_o", flags[2], oup_gnt_o);
        check_bit("oup_data_valid_o", flags[1], oup_data_valid_o);
        check_bit("exists_o", flags[0], exists_o);
        // The search grant simply mirrors its request
        check_bit("exists_gnt_o", vec[76], exists_gnt_o);
        // Output data is don't care while the valid flag is low
        if (flags[1]) begin
            check_data("oup_data_o", vec[15:0], oup_data_o);
        end
    endtask

    initial begin
        int num_lines;
        rst_ni        = 1'b0;
        inp_req_i     = 1'b0;
        inp_id_i      = '0;
        inp_data_i    = '0;
        oup_req_i     = 1'b0;
        oup_id_i      = '0;
        oup_pop_i     = 1'b0;
        exists_req_i  = 1'b0;
        exists_data_i = '0;
        exists_mask_i = '0;

        // All ones marks the entries that the file did not fill
        for (int i = 0; i < MAX_LINES; i++) begin
            vectors[i] = '1;
        end
        $readmemh("idq_testdata.txt", vectors);
        num_lines = 0;
        while (num_lines < MAX_LINES && vectors[num_lines] != '1) begin
            num_lines++;
        end
        if (num_lines == 0) begin
            $display("No test lines could be loaded from idq_testdata.txt");
            $display("TESTBENCH FAILED");
            $fatal(1, "Missing test data");
        end
        timeout_limit = 2 * num_lines + 30;

        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        // Outputs are combinational, so they settle 1 ns after the falling edge
        for (int n = 0; n < num_lines; n++) begin
            @(negedge clk_i);
            line_no = n + 1;
            apply_vector(vectors[n]);
            #1;
            check_outputs(vectors[n]);
        end

        @(negedge clk_i);
        inp_req_i    = 1'b0;
        oup_req_i    = 1'b0;
        exists_req_i = 1'b0;
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* idq_testdata.txt */
// Columns: op iid idata oid xdata xmask flags odata, op bits: push out pop search
// Flags bits: inp_gnt oup_gnt valid exists, odata is only checked when valid is set
0_0_0000_0_0000_0000_8_0000
1_0_0000_0_0000_0000_8_0000
4_0_0000_2_0000_0000_C_0000
6_0_0000_5_0000_0000_C_0000
// Interleaved pushes under IDs 2 and 5
8_2_A201_0_0000_0000_8_0000
8_5_5501_0_0000_0000_8_0000
8_2_A202_0_0000_0000_8_0000
8_5_5502_0_0000_0000_8_0000
8_2_A203_0_0000_0000_8_0000
// Reads leave the head in place, pops follow push order per ID
4_0_0000_2_0000_0000_E_A201
4_0_0000_2_0000_0000_E_A201
6_0_0000_2_0000_0000_E_A201
4_0_0000_5_0000_0000_E_5501
6_0_0000_5_0000_0000_E_5501
6_0_0000_2_0000_0000_E_A202
6_0_0000_5_0000_0000_E_5502
6_0_0000_5_0000_0000_C_0000
8_5_5503_0_0000_0000_8_0000
4_0_0000_5_0000_0000_E_5503
// Masked search over the stored words
1_0_0000_0_A203_FFFF_9_0000
1_0_0000_0_A2FF_FF00_9_0000
1_0_0000_0_1234_FFFF_8_0000
1_0_0000_0_0000_0000_9_0000
5_0_0000_2_5503_FFFF_F_A203
// Push wins over a read, then the queue fills up
C_6_6601_2_0000_0000_8_0000
8_6_6602_0_0000_0000_8_0000
8_6_6603_0_0000_0000_8_0000
8_7_7701_0_0000_0000_8_0000
8_7_7702_0_0000_0000_8_0000
8_2_A204_0_0000_0000_8_0000
0_0_0000_0_0000_0000_0_0000
C_3_3301_6_0000_0000_6_6601
E_3_3301_2_0000_0000_6_A203
8_3_3301_0_0000_0000_8_0000
0_0_0000_0_0000_0000_0_0000
1_0_0000_0_A203_FFFF_0_0000
6_0_0000_3_0000_0000_6_3301
1_0_0000_0_3301_FFFF_8_0000
6_0_0000_2_0000_0000_E_A204
6_0_0000_2_0000_0000_C_0000
6_0_0000_6_0000_0000_E_6601
0_0_0000_0_6603_FFFF_8_0000

/* sources.f */
idq_cfg_pkg.sv
idq_op_pkg.sv
idq_port_arbiter.sv
idq_head_tail_table.sv
idq_linked_data_table.sv
idq_exists_search.sv
id_queue_top.sv
tb_id_queue.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_id_queue -f sources.f

# The simulation exits non-zero on $fatal, the log decides the result below
./obj_dir/Vtb_id_queue > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
grep -q "TESTBENCH PASSED" sim.log
